/* pulse_consts.svh */
`ifndef PULSE_CONSTS_SVH
`define PULSE_CONSTS_SVH

////////////////////////////////////////
// Channel counts
////////////////////////////////////////

`define PULSE_NUM_SHUTTER 16
`define PULSE_NUM_TRIGGER 16

// Only the lower shutter channels get a delay line
`define PULSE_NUM_DELAYED 8
`define PULSE_DELAY_BITS 8
`define PULSE_DELAY_DEPTH 256

////////////////////////////////////////
// Host stream and register bank
////////////////////////////////////////

`define PULSE_HOST_WORD 16
`define PULSE_EXT_DATA 64

// One address word, then four data words low word first
`define PULSE_WORDS_PER_WRITE 5

`define PULSE_ADDR_SHUTTER 16'h0010
`define PULSE_ADDR_TRIGGER 16'h0011
`define PULSE_ADDR_DELAY 16'h0013

// Set in the address word to skip staging
`define PULSE_APPLY_BIT 15

`endif

/* pulse_pkg.sv */
`include "pulse_consts.svh"

package pulse_pkg;

	// Host stream
	typedef logic [`PULSE_HOST_WORD-1:0] host_word_t;

	// Address without the apply bit
	typedef logic [`PULSE_APPLY_BIT-1:0] ext_addr_t;
	typedef logic [`PULSE_EXT_DATA-1:0] ext_data_t;

	// Output vectors
	typedef logic [`PULSE_NUM_SHUTTER-1:0] shutter_t;
	typedef logic [`PULSE_NUM_TRIGGER-1:0] trigger_t;

	// Delay of one channel, also the tap index
	typedef logic [`PULSE_DELAY_BITS-1:0] delay_t;

	// Position of a word within one transfer
	typedef logic [$clog2(`PULSE_WORDS_PER_WRITE)-1:0] word_count_t;

endpackage

/* ext_wire_if.sv */
`timescale 1ns/1ps

interface ext_wire_if import pulse_pkg::*; ();

	ext_addr_t ext_addr;
	ext_data_t ext_data;
	// One cycle strobe, the others hold while it is high
	logic ext_update;
	logic ext_apply_now;

	modport source (
		output ext_addr,
		output ext_data,
		output ext_update,
		output ext_apply_now
	);

	modport sink (
		input ext_addr,
		input ext_data,
		input ext_update,
		input ext_apply_now
	);

endinterface

/* ext_wire_deserializer.sv */
`timescale 1ns/1ps
`include "pulse_consts.svh"

module ext_wire_deserializer import pulse_pkg::*; (
	input logic clk,
	input logic ti_reset,
	input host_word_t host_word_i,
	input logic host_write_i,
	ext_wire_if.source ext
);

	localparam word_count_t LAST_WORD = word_count_t'(`PULSE_WORDS_PER_WRITE - 1);
	localparam int WORD_W = `PULSE_HOST_WORD;

	word_count_t word_cnt;
	logic last_word;

	assign last_word = (word_cnt == LAST_WORD);

	////////////////////////////////////////
	// Word counter and update strobe
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (ti_reset) begin
			word_cnt <= '0;
			ext.ext_update <= 1'b0;
		end else begin
			ext.ext_update <= host_write_i && last_word;
			if (host_write_i) begin
				// Wrap right away so transfers can follow back to back
				if (last_word) begin
					word_cnt <= '0;
				end else begin
					word_cnt <= word_cnt + word_count_t'(1);
				end
			end
		end
	end

	////////////////////////////////////////
	// Address and data assembly
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (host_write_i) begin
			if (word_cnt == '0) begin
				ext.ext_addr <= host_word_i[`PULSE_APPLY_BIT-1:0];
				ext.ext_apply_now <= host_word_i[`PULSE_APPLY_BIT];
			end else begin
				// Words 1 to 4 land from the low end up
				ext.ext_data[(int'(word_cnt) - 1) * WORD_W +: WORD_W] <= host_word_i;
			end
		end
	end

endmodule

/* ext_wire_register.sv */
`timescale 1ns/1ps
`include "pulse_consts.svh"

module ext_wire_register import pulse_pkg::*; #(
	parameter host_word_t MY_ADDRESS = 16'h0000
) (
	input logic clk,
	input logic ti_reset,
	ext_wire_if.sink ext,
	input logic pp_update_i,
	output ext_data_t value_o
);

	localparam ext_addr_t MATCH_ADDR = MY_ADDRESS[`PULSE_APPLY_BIT-1:0];

	ext_data_t staged;
	logic pending;
	logic hit;

	assign hit = ext.ext_update && (ext.ext_addr == MATCH_ADDR);

	// Staged copy waits for the sequencer update pulse
	always_ff @(posedge clk) begin
		if (hit && !ext.ext_apply_now) begin
			staged <= ext.ext_data;
		end
	end

	always_ff @(posedge clk) begin
		if (ti_reset) begin
			value_o <= '0;
			pending <= 1'b0;
		end else begin
			// Older staged value goes live first
			if (pp_update_i && pending) begin
				value_o <= staged;
				pending <= 1'b0;
			end
			if (hit) begin
				if (ext.ext_apply_now) begin
					value_o <= ext.ext_data;
				end else begin
					pending <= 1'b1;
				end
			end
		end
	end

endmodule

/* shutter_delay_line.sv */
`timescale 1ns/1ps
`include "pulse_consts.svh"

module shutter_delay_line import pulse_pkg::*; (
	input logic clk,
	input logic ti_reset,
	input shutter_t shutter_i,
	input ext_data_t delay_cfg_i,
	output shutter_t shutter_o
);

	localparam int NUM_DELAYED = `PULSE_NUM_DELAYED;
	localparam int DELAY_W = `PULSE_DELAY_BITS;
	localparam int DEPTH = `PULSE_DELAY_DEPTH;

	logic [NUM_DELAYED-1:0] delayed;

	////////////////////////////////////////
	// Lower channels
	////////////////////////////////////////

	for (genvar c = 0; c < NUM_DELAYED; c++) begin : g_chan
		// history[0] is the newest sample
		logic [DEPTH-2:0] history;
		logic [DEPTH-1:0] taps;
		delay_t tap_sel;

		assign tap_sel = delay_cfg_i[c * DELAY_W +: DELAY_W];

		// Tap 0 is the live input, tap n is n cycles old
		assign taps = {history, shutter_i[c]};

		always_ff @(posedge clk) begin
			if (ti_reset) begin
				history <= '0;
			end else begin
				history <= {history[DEPTH-3:0], shutter_i[c]};
			end
		end

		assign delayed[c] = taps[tap_sel];
	end

	////////////////////////////////////////
	// Upper channels pass straight through
	////////////////////////////////////////

	assign shutter_o = {shutter_i[`PULSE_NUM_SHUTTER-1:NUM_DELAYED], delayed};

endmodule

/* output_stage.sv */
`timescale 1ns/1ps

module output_stage import pulse_pkg::*; (
	input logic clk,
	input logic ti_reset,
	input logic pp_active_i,
	input trigger_t pp_trigger_i,
	input shutter_t pp_shutter_delayed_i,
	input shutter_t host_shutter_i,
	input trigger_t host_trigger_mask_i,
	input logic host_trig_i,
	output trigger_t trigger_o,
	output shutter_t shutter_o
);

	logic host_trig_q;
	logic host_trig_pulse;
	trigger_t host_trigger;

	////////////////////////////////////////
	// Host trigger
	////////////////////////////////////////

	// Rising edge of the host level gives a single cycle pulse
	always_ff @(posedge clk) begin
		if (ti_reset) begin
			host_trig_q <= 1'b0;
			host_trig_pulse <= 1'b0;
		end else begin
			host_trig_q <= host_trig_i;
			host_trig_pulse <= host_trig_i && !host_trig_q;
		end
	end

	// Mask is fired for the one cycle after the pulse
	always_ff @(posedge clk) begin
		if (ti_reset) begin
			host_trigger <= '0;
		end else begin
			host_trigger <= host_trig_pulse ? host_trigger_mask_i : '0;
		end
	end

	////////////////////////////////////////
	// Output registers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (ti_reset) begin
			trigger_o <= '0;
			shutter_o <= '0;
		end else begin
			// Sequencer owns the outputs while it runs
			trigger_o <= pp_active_i ? pp_trigger_i : host_trigger;
			shutter_o <= pp_active_i ? pp_shutter_delayed_i : host_shutter_i;
		end
	end

endmodule

/* pulse_output_top.sv */
`timescale 1ns/1ps
`include "pulse_consts.svh"

module pulse_output_top import pulse_pkg::*; (
	input logic clk,
	input logic ti_reset,

	// Host extended wire stream
	input host_word_t host_word_i,
	input logic host_write_i,
	input logic host_trig_i,

	// Sequencer side
	input logic pp_active_i,
	input logic pp_update_i,
	input shutter_t pp_shutter_i,
	input trigger_t pp_trigger_i,

	output shutter_t shutter_o,
	output trigger_t trigger_o
);

	ext_data_t host_shutter_reg;
	ext_data_t host_trigger_reg;
	ext_data_t delay_cfg;
	shutter_t pp_shutter_delayed;

	ext_wire_if ext_bus ();

	////////////////////////////////////////
	// Extended wire path
	////////////////////////////////////////

	ext_wire_deserializer u_deser (
		.clk (clk),
		.ti_reset (ti_reset),
		.host_word_i (host_word_i),
		.host_write_i (host_write_i),
		.ext (ext_bus)
	);

	ext_wire_register #(
		.MY_ADDRESS (`PULSE_ADDR_SHUTTER)
	) u_reg_shutter (
		.clk (clk),
		.ti_reset (ti_reset),
		.ext (ext_bus),
		.pp_update_i (pp_update_i),
		.value_o (host_shutter_reg)
	);

	ext_wire_register #(
		.MY_ADDRESS (`PULSE_ADDR_TRIGGER)
	) u_reg_trigger (
		.clk (clk),
		.ti_reset (ti_reset),
		.ext (ext_bus),
		.pp_update_i (pp_update_i),
		.value_o (host_trigger_reg)
	);

	// Eight 8-bit delays, channel 0 in the low byte
	ext_wire_register #(
		.MY_ADDRESS (`PULSE_ADDR_DELAY)
	) u_reg_delay (
		.clk (clk),
		.ti_reset (ti_reset),
		.ext (ext_bus),
		.pp_update_i (pp_update_i),
		.value_o (delay_cfg)
	);

	////////////////////////////////////////
	// Shutter delay and output selection
	////////////////////////////////////////

	shutter_delay_line u_delay (
		.clk (clk),
		.ti_reset (ti_reset),
		.shutter_i (pp_shutter_i),
		.delay_cfg_i (delay_cfg),
		.shutter_o (pp_shutter_delayed)
	);

	output_stage u_out (
		.clk (clk),
		.ti_reset (ti_reset),
		.pp_active_i (pp_active_i),
		.pp_trigger_i (pp_trigger_i),
		.pp_shutter_delayed_i (pp_shutter_delayed),
		.host_shutter_i (host_shutter_reg[`PULSE_NUM_SHUTTER-1:0]),
		.host_trigger_mask_i (host_trigger_reg[`PULSE_NUM_TRIGGER-1:0]),
		.host_trig_i (host_trig_i),
		.trigger_o (trigger_o),
		.shutter_o (shutter_o)
	);

endmodule

/* pulse_checker.sv */
`timescale 1ns/1ps
`include "pulse_consts.svh"

module pulse_checker import pulse_pkg::*; (
	input logic clk,
	input logic ti_reset,
	input host_word_t host_word_i,
	input logic host_write_i,
	input logic host_trig_i,
	input logic pp_active_i,
	input logic pp_update_i,
	input shutter_t pp_shutter_i,
	input trigger_t pp_trigger_i,
	input shutter_t dut_shutter_i,
	input trigger_t dut_trigger_i,
	output int err_count_o,
	output int check_count_o
);

	localparam int NUM_REGS = 3;
	localparam int NUM_DELAYED = `PULSE_NUM_DELAYED;
	localparam int DELAY_W = `PULSE_DELAY_BITS;
	localparam int DEPTH = `PULSE_DELAY_DEPTH;

	// Register 0 shutter, 1 trigger mask, 2 delays
	ext_data_t live [NUM_REGS];
	ext_data_t staged [NUM_REGS];
	logic pending [NUM_REGS];
	ext_addr_t reg_addr [NUM_REGS];

	int word_pos;
	ext_addr_t cur_addr;
	logic cur_apply;
	ext_data_t cur_data;
	// Transfer completed at the previous edge
	logic upd_valid;
	ext_addr_t upd_addr;
	logic upd_apply;
	ext_data_t upd_data;

	// hist[c][0] is the sample taken one edge ago
	logic [DEPTH-2:0] hist [NUM_DELAYED];
	logic trig_q;
	logic trig_pulse;
	trigger_t host_fire;
	shutter_t exp_shutter;
	trigger_t exp_trigger;
	logic armed;

	initial begin
		err_count_o = 0;
		check_count_o = 0;
		armed = 1'b0;
		reg_addr[0] = ext_addr_t'(`PULSE_ADDR_SHUTTER);
		reg_addr[1] = ext_addr_t'(`PULSE_ADDR_TRIGGER);
		reg_addr[2] = ext_addr_t'(`PULSE_ADDR_DELAY);
	end

	////////////////////////////////////////
	// Reference model, one step per edge
	////////////////////////////////////////

	always @(posedge clk) begin : model_step
		shutter_t delayed;
		int d;
		if (ti_reset) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				live[r] = '0;
				staged[r] = '0;
				pending[r] = 1'b0;
			end
			for (int c = 0; c < NUM_DELAYED; c++) begin
				hist[c] = '0;
			end
			word_pos = 0;
			upd_valid = 1'b0;
			trig_q = 1'b0;
			trig_pulse = 1'b0;
			host_fire = '0;
			exp_shutter = '0;
			exp_trigger = '0;
			armed = 1'b1;
		end else begin
			// Outputs come from the state before this edge
			delayed = pp_shutter_i;
			for (int c = 0; c < NUM_DELAYED; c++) begin
				d = int'(live[2][c * DELAY_W +: DELAY_W]);
				if (d != 0) begin
					delayed[c] = hist[c][d - 1];
				end
				hist[c] = {hist[c][DEPTH-3:0], pp_shutter_i[c]};
			end
			exp_trigger = pp_active_i ? pp_trigger_i : host_fire;
			exp_shutter = pp_active_i ? delayed : live[0][`PULSE_NUM_SHUTTER-1:0];
			host_fire = trig_pulse ? live[1][`PULSE_NUM_TRIGGER-1:0] : '0;
			trig_pulse = host_trig_i && !trig_q;
			trig_q = host_trig_i;

			for (int r = 0; r < NUM_REGS; r++) begin
				if (pp_update_i && pending[r]) begin
					live[r] = staged[r];
					pending[r] = 1'b0;
				end
				if (upd_valid && upd_addr == reg_addr[r]) begin
					if (upd_apply) begin
						live[r] = upd_data;
					end else begin
						staged[r] = upd_data;
						pending[r] = 1'b1;
					end
				end
			end

			upd_valid = 1'b0;
			if (host_write_i) begin
				if (word_pos == 0) begin
					cur_addr = host_word_i[`PULSE_APPLY_BIT-1:0];
					cur_apply = host_word_i[`PULSE_APPLY_BIT];
				end else begin
					cur_data[(word_pos - 1) * `PULSE_HOST_WORD +: `PULSE_HOST_WORD] = host_word_i;
				end
				if (word_pos == `PULSE_WORDS_PER_WRITE - 1) begin
					upd_valid = 1'b1;
					upd_addr = cur_addr;
					upd_apply = cur_apply;
					upd_data = cur_data;
					word_pos = 0;
				end else begin
					word_pos++;
				end
			end
		end
	end

	// Outputs settle well before the falling edge
	always @(negedge clk) begin
		if (armed) begin
			check_count_o++;
			if (dut_shutter_i !== exp_shutter) begin
				err_count_o++;
				$display("ERR %0t: shutter_o is %h, expected %h", $time, dut_shutter_i,
					exp_shutter);
			end
			if (dut_trigger_i !== exp_trigger) begin
				err_count_o++;
				$display("ERR %0t: trigger_o is %h, expected %h", $time, dut_trigger_i,
					exp_trigger);
			end
		end
	end

endmodule

/* tb_pulse_output.sv */
`timescale 1ns/1ps
`include "pulse_consts.svh"

module tb_pulse_output import pulse_pkg::*; ();

	localparam int CLK_HALF = 10;
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY = 2;
	localparam logic [31:0] SEED = 32'h2ad3;
	localparam int N_IMM = 40;
	localparam int N_STAGED = 30;
	localparam int N_TRIG = 40;
	localparam int N_PASS = 300;
	localparam int N_DELAY_CFG = 3;
	localparam int DELAY_RUN = 300;
	localparam int N_MIXED = 400;
	// Longest path through each phase
	localparam int RUN_ESTIMATE = RESET_CYCLES + N_IMM * 9 + N_STAGED * 19 + N_TRIG * 10 + 24
		+ N_PASS + N_DELAY_CFG * (DELAY_RUN + 6) + N_MIXED + 10;
	localparam int TIMEOUT_CYCLES = RUN_ESTIMATE + RUN_ESTIMATE / 3;

	logic clk;
	logic ti_reset;
	host_word_t host_word;
	logic host_write;
	logic host_trig;
	logic pp_active;
	logic pp_update;
	shutter_t pp_shutter;
	trigger_t pp_trigger;
	shutter_t shutter;
	trigger_t trigger;
	int err_count;
	int check_count;
	int cycle_count;
	logic [31:0] rng_state;

	pulse_output_top DUT (
		.clk (clk),
		.ti_reset (ti_reset),
		.host_word_i (host_word),
		.host_write_i (host_write),
		.host_trig_i (host_trig),
		.pp_active_i (pp_active),
		.pp_update_i (pp_update),
		.pp_shutter_i (pp_shutter),
		.pp_trigger_i (pp_trigger),
		.shutter_o (shutter),
		.trigger_o (trigger)
	);

	pulse_checker u_check (
		.clk (clk),
		.ti_reset (ti_reset),
		.host_word_i (host_word),
		.host_write_i (host_write),
		.host_trig_i (host_trig),
		.pp_active_i (pp_active),
		.pp_update_i (pp_update),
		.pp_shutter_i (pp_shutter),
		.pp_trigger_i (pp_trigger),
		.dut_shutter_i (shutter),
		.dut_trigger_i (trigger),
		.err_count_o (err_count),
		.check_count_o (check_count)
	);

	always #CLK_HALF clk = ~clk;

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state ^ (rng_state >> 15);
	endfunction

	function automatic ext_data_t rand_delays();
		ext_data_t cfg;
		logic [31:0] r;
		for (int c = 0; c < `PULSE_NUM_DELAYED; c++) begin
			r = next_rand();
			case (r[1:0])
				2'd0: cfg[c * 8 +: 8] = 8'd0;
				2'd1: cfg[c * 8 +: 8] = 8'd255;
				default: cfg[c * 8 +: 8] = r[15:8];
			endcase
		end
		return cfg;
	endfunction

	task automatic step();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic send_write(input logic [15:0] addr, input logic apply, input ext_data_t data);
		host_write = 1'b1;
		host_word = {apply, addr[14:0]};
		step();
		for (int i = 0; i < 4; i++) begin
			host_word = data[i * 16 +: 16];
			step();
		end
		host_write = 1'b0;
	endtask

	task automatic pulse_update();
		pp_update = 1'b1;
		step();
		pp_update = 1'b0;
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin : stimulus
		logic [31:0] r;
		logic [31:0] r2;
		ext_data_t cfg;
		int mix_pos;
		clk = 1'b0;
		ti_reset = 1'b1;
		host_word = '0;
		host_write = 1'b0;
		host_trig = 1'b0;
		pp_active = 1'b0;
		pp_update = 1'b0;
		pp_shutter = '0;
		pp_trigger = '0;
		cycle_count = 0;
		rng_state = SEED;
		repeat (RESET_CYCLES) step();
		ti_reset = 1'b0;

		// Immediate and staged shutter writes while the host owns the outputs
		repeat (N_IMM) begin
			send_write(`PULSE_ADDR_SHUTTER, 1'b1, {next_rand(), next_rand()});
			repeat (4) step();
		end
		repeat (N_STAGED) begin
			send_write(`PULSE_ADDR_SHUTTER, 1'b0, {next_rand(), next_rand()});
			repeat (next_rand() % 8) step();
			pulse_update();
			repeat (3) step();
			pulse_update();
			repeat (2) step();
		end

		// Host trigger edges, the level is held for a random time
		for (int i = 0; i < N_TRIG; i++) begin
			if (i % 10 == 0) begin
				send_write(`PULSE_ADDR_TRIGGER, 1'b1, {next_rand(), next_rand()});
			end
			host_trig = 1'b1;
			repeat (1 + next_rand() % 6) step();
			host_trig = 1'b0;
			repeat (1 + next_rand() % 4) step();
		end

		pp_active = 1'b1;
		repeat (N_PASS) begin
			r = next_rand();
			pp_shutter = r[15:0];
			pp_trigger = r[31:16];
			step();
		end

		////////////////////////////////////////
		// Per channel delays
		////////////////////////////////////////

		for (int i = 0; i < N_DELAY_CFG; i++) begin
			cfg = rand_delays();
			if (i == 0) begin
				cfg[7:0] = 8'd0;
				cfg[63:56] = 8'd255;
			end
			send_write(`PULSE_ADDR_DELAY, i != 1, cfg);
			if (i == 1) begin
				// Let the write be staged before the update goes live
				step();
				pulse_update();
			end
			repeat (DELAY_RUN) begin
				r = next_rand();
				pp_shutter = r[15:0];
				step();
			end
		end

		// Unused addresses mixed with source switching
		mix_pos = 0;
		repeat (N_MIXED) begin
			r = next_rand();
			r2 = next_rand();
			if (r[2:0] == 3'd0) begin
				pp_active = ~pp_active;
			end
			if (r[5:3] == 3'd0) begin
				host_trig = ~host_trig;
			end
			pp_update = (r[9:6] == 4'd0);
			pp_shutter = r2[15:0];
			pp_trigger = r2[31:16];
			host_write = r[10] | r[11];
			if (host_write) begin
				if (mix_pos == 0) begin
					host_word = r[12] ? {r[13], 15'h0012} : {r[13], 1'b1, r[27:14]};
				end else begin
					host_word = r[31:16];
				end
				mix_pos = (mix_pos == 4) ? 0 : mix_pos + 1;
			end
			step();
		end
		host_write = 1'b0;
		pp_update = 1'b0;
		repeat (10) step();

		$display("Run finished with %0d errors in %0d checks", err_count, check_count);
		if (err_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
+incdir+.
pulse_pkg.sv
ext_wire_if.sv
ext_wire_deserializer.sv
ext_wire_register.sv
shutter_delay_line.sv
output_stage.sv
pulse_output_top.sv
pulse_checker.sv
tb_pulse_output.sv
